// File: source/codec_cfg_pkg.sv
package codec_cfg_pkg;

    // Codec register map widths
    typedef logic [6:0] reg_addr_t;
    typedef logic [8:0] reg_data_t;
    typedef logic [6:0] dev_addr_t;   // 7-bit bus address, R/W bit added by the writer
    typedef logic [6:0] volume_t;     // Headphone volume code

    // One register write, 16 bits
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
    } codec_write_t;

    typedef enum logic [1:0] {
        INIT_IDLE,
        INIT_REQUEST,
        INIT_WAIT_DONE,
        INIT_NEXT
    } init_state_t;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_START,
        WR_LOW,
        WR_HIGH,
        WR_STOP_LOW,
        WR_STOP_HIGH
    } writer_state_t;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_INIT,
        OWN_VOLUME
    } arb_owner_t;

endpackage

// File: source/codec_init_seq.sv
module codec_init_seq import codec_cfg_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_start,
    input  logic         i_done,
    output logic         o_req,
    output codec_write_t o_wr,
    output logic         o_finished
);

    localparam logic [2:0] LAST_IDX = 3'd6;

    init_state_t  state_q;
    logic [2:0]   idx_q;
    logic         start_q;
    logic         finished_q;
    logic         start_rise;
    codec_write_t table_wr;

    assign start_rise = i_start && !start_q;

    // Power-up table, one write per entry
    always_comb begin
        case (idx_q)
            3'd0:    table_wr = '{addr: 7'h0F, data: 9'h000}; // Reset
            3'd1:    table_wr = '{addr: 7'h04, data: 9'h015}; // Analogue path
            3'd2:    table_wr = '{addr: 7'h05, data: 9'h000}; // Digital path
            3'd3:    table_wr = '{addr: 7'h06, data: 9'h000}; // Power down
            3'd4:    table_wr = '{addr: 7'h07, data: 9'h042}; // Interface format
            3'd5:    table_wr = '{addr: 7'h08, data: 9'h019}; // Sampling
            default: table_wr = '{addr: 7'h09, data: 9'h001}; // Active
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_q    <= INIT_IDLE;
            idx_q      <= 3'd0;
            start_q    <= 1'b0;
            finished_q <= 1'b0;
        end else begin
            start_q <= i_start;
            case (state_q)
                INIT_IDLE: begin
                    if (start_rise) begin
                        idx_q      <= 3'd0;
                        finished_q <= 1'b0;   // Cleared by a new run
                        state_q    <= INIT_REQUEST;
                    end
                end
                INIT_REQUEST: state_q <= INIT_WAIT_DONE;
                INIT_WAIT_DONE: begin
                    if (i_done) begin
                        if (idx_q == LAST_IDX) begin
                            finished_q <= 1'b1;
                            state_q    <= INIT_IDLE;
                        end else begin
                            idx_q   <= idx_q + 3'd1;
                            state_q <= INIT_NEXT;
                        end
                    end
                end
                // Request stays up here so the arbiter keeps us as owner
                INIT_NEXT: state_q <= INIT_WAIT_DONE;
                default: state_q <= INIT_IDLE;
            endcase
        end
    end

    assign o_req      = (state_q != INIT_IDLE);
    assign o_wr       = table_wr;
    assign o_finished = finished_q;

endmodule

// File: source/codec_volume_ctrl.sv
module codec_volume_ctrl import codec_cfg_pkg::*; #(
    parameter volume_t VOL_RESET = 7'h79,
    parameter volume_t VOL_MIN   = 7'h30
) (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_vol_up,
    input  logic         i_vol_down,
    input  logic         i_done,
    output logic         o_req,
    output codec_write_t o_wr,
    output volume_t      o_volume
);

    localparam volume_t   VOL_MAX = 7'h7F;
    localparam reg_addr_t VOL_REG = 7'h02;   // Left headphone out

    volume_t vol_q;
    volume_t wr_vol_q;     // Value carried by the current or last request
    logic    pending_q;
    volume_t vol_next;

    // Saturating step, out-of-range pulses leave the code alone
    always_comb begin
        vol_next = vol_q;
        if (i_vol_up && !i_vol_down && vol_q != VOL_MAX) begin
            vol_next = vol_q + 7'd1;
        end else if (i_vol_down && !i_vol_up && vol_q > VOL_MIN) begin
            vol_next = vol_q - 7'd1;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            vol_q     <= VOL_RESET;
            wr_vol_q  <= VOL_RESET;
            pending_q <= 1'b0;
        end else begin
            vol_q <= vol_next;
            if (pending_q) begin
                if (i_done) pending_q <= 1'b0;
            end else if (vol_q != wr_vol_q) begin
                // Pulses seen while pending fold into one follow-up write
                wr_vol_q  <= vol_q;
                pending_q <= 1'b1;
            end
        end
    end

    assign o_req    = pending_q;
    assign o_wr     = '{addr: VOL_REG, data: {1'b1, 1'b0, wr_vol_q}}; // Bit 8 links both channels
    assign o_volume = vol_q;

endmodule

// File: source/i2c_bus_arbiter.sv
module i2c_bus_arbiter import codec_cfg_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_init_req,
    input  logic         i_vol_req,
    input  codec_write_t i_init_wr,
    input  codec_write_t i_vol_wr,
    input  logic         i_busy,
    input  logic         i_done,
    output logic         o_start,
    output codec_write_t o_payload,
    output logic         o_init_done,
    output logic         o_vol_done
);

    arb_owner_t owner_q;
    logic       inflight_q;   // Granted frame not yet finished
    logic       can_grant;
    logic       grant_init;
    logic       grant_vol;

    assign can_grant  = !inflight_q && !i_busy;
    assign grant_init = can_grant && i_init_req && (owner_q != OWN_VOLUME);
    assign grant_vol  = can_grant && i_vol_req && !i_init_req && (owner_q == OWN_NONE);

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            owner_q    <= OWN_NONE;
            inflight_q <= 1'b0;
        end else if (grant_init) begin
            owner_q    <= OWN_INIT;
            inflight_q <= 1'b1;
        end else if (grant_vol) begin
            owner_q    <= OWN_VOLUME;
            inflight_q <= 1'b1;
        end else if (i_done) begin
            inflight_q <= 1'b0;
            if (owner_q == OWN_VOLUME) owner_q <= OWN_NONE; // INIT is held for its next entry
        end else if (!inflight_q && owner_q == OWN_INIT && !i_init_req) begin
            owner_q <= OWN_NONE;  // Sequence over
        end
    end

    // Payload must be valid in the grant cycle, before owner_q updates
    always_comb begin
        if (grant_vol || owner_q == OWN_VOLUME) begin
            o_payload = i_vol_wr;
        end else begin
            o_payload = i_init_wr;
        end
    end

    assign o_start     = grant_init || grant_vol;
    assign o_init_done = i_done && (owner_q == OWN_INIT);
    assign o_vol_done  = i_done && (owner_q == OWN_VOLUME);

endmodule

// File: source/i2c_reg_writer.sv
module i2c_reg_writer import codec_cfg_pkg::*; #(
    parameter dev_addr_t DEV_ADDR    = 7'h1A,
    parameter int        HALF_PERIOD = 4
) (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_start,
    input  codec_write_t i_payload,
    output logic         o_busy,
    output logic         o_done,
    output logic         o_scl,
    output logic         o_sda,
    output logic         o_oen
);

    localparam int          CNT_W     = $clog2(HALF_PERIOD + 1);
    localparam logic [4:0]  LAST_SLOT = 5'd26;
    // Acknowledge slots 8, 17 and 26, MSB first
    localparam logic [26:0] ACK_MASK  = 27'b000000001_000000001_000000001;

    writer_state_t    state_q;
    logic [CNT_W-1:0] half_cnt_q;
    logic [4:0]       slot_q;
    logic [26:0]      frame_q;
    logic [26:0]      ack_q;
    logic             scl_q;
    logic             sda_q;
    logic             oen_q;
    logic             done_q;
    logic             half_end;
    logic             bit_load;

    assign half_end = (half_cnt_q == CNT_W'(HALF_PERIOD - 1));

    // Next slot begins: after the start hold or after a non-final high phase
    assign bit_load = half_end && ((state_q == WR_START) ||
                      (state_q == WR_HIGH && slot_q != LAST_SLOT));

    // Frame shifter, ack slots carry a released 1
    always_ff @(posedge i_clk) begin
        if (state_q == WR_IDLE && i_start) begin
            frame_q <= {DEV_ADDR, 1'b0, 1'b1,
                        i_payload.addr, i_payload.data[8], 1'b1,
                        i_payload.data[7:0], 1'b1};
            ack_q   <= ACK_MASK;
        end else if (bit_load) begin
            frame_q <= {frame_q[25:0], 1'b1};
            ack_q   <= {ack_q[25:0], 1'b0};
        end
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_q    <= WR_IDLE;
            half_cnt_q <= '0;
            slot_q     <= 5'd0;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            oen_q      <= 1'b1;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (state_q == WR_IDLE || half_end) begin
                half_cnt_q <= '0;
            end else begin
                half_cnt_q <= half_cnt_q + 1'b1;
            end

            if (bit_load) begin
                scl_q <= 1'b0;
                sda_q <= frame_q[26];
                oen_q <= !ack_q[26];   // Release the pin for the slave's ack
            end

            case (state_q)
                WR_IDLE: begin
                    if (i_start) begin
                        sda_q   <= 1'b0;          // Start, SCL still high
                        slot_q  <= 5'd0;
                        state_q <= WR_START;
                    end
                end
                WR_START: begin
                    if (half_end) state_q <= WR_LOW;
                end
                WR_LOW: begin
                    if (half_end) begin
                        scl_q   <= 1'b1;
                        state_q <= WR_HIGH;
                    end
                end
                WR_HIGH: begin
                    if (half_end) begin
                        if (slot_q == LAST_SLOT) begin
                            scl_q   <= 1'b0;
                            sda_q   <= 1'b0;
                            oen_q   <= 1'b1;
                            state_q <= WR_STOP_LOW;
                        end else begin
                            slot_q  <= slot_q + 5'd1;
                            state_q <= WR_LOW;
                        end
                    end
                end
                WR_STOP_LOW: begin
                    if (half_end) begin
                        scl_q   <= 1'b1;
                        state_q <= WR_STOP_HIGH;
                    end
                end
                WR_STOP_HIGH: begin
                    if (half_end) begin
                        sda_q   <= 1'b1;          // Stop, SDA rises with SCL high
                        done_q  <= 1'b1;
                        state_q <= WR_IDLE;
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    assign o_busy = (state_q != WR_IDLE);
    assign o_done = done_q;
    assign o_scl  = scl_q;
    assign o_sda  = sda_q;
    assign o_oen  = oen_q;

endmodule

// File: source/codec_cfg_top.sv
module codec_cfg_top import codec_cfg_pkg::*; #(
    parameter dev_addr_t DEV_ADDR    = 7'h1A,
    parameter int        HALF_PERIOD = 4,
    parameter volume_t   VOL_RESET   = 7'h79,
    parameter volume_t   VOL_MIN     = 7'h30
) (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_start,
    input  logic    i_vol_up,
    input  logic    i_vol_down,
    output logic    o_finished,
    output volume_t o_volume,
    output logic    o_scl,
    output logic    o_sda,
    output logic    o_oen
);

    logic         init_req;
    logic         vol_req;
    codec_write_t init_wr;
    codec_write_t vol_wr;
    logic         init_done;
    logic         vol_done;
    logic         wr_start;
    codec_write_t wr_payload;
    logic         wr_done;
    logic         wr_busy;

    codec_init_seq u_init_seq (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (i_start),
        .i_done     (init_done),
        .o_req      (init_req),
        .o_wr       (init_wr),
        .o_finished (o_finished)
    );

    codec_volume_ctrl #(
        .VOL_RESET (VOL_RESET),
        .VOL_MIN   (VOL_MIN)
    ) u_volume_ctrl (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_vol_up   (i_vol_up),
        .i_vol_down (i_vol_down),
        .i_done     (vol_done),
        .o_req      (vol_req),
        .o_wr       (vol_wr),
        .o_volume   (o_volume)
    );

    // Init has priority and keeps the bus for the whole sequence
    i2c_bus_arbiter u_arbiter (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_init_req  (init_req),
        .i_vol_req   (vol_req),
        .i_init_wr   (init_wr),
        .i_vol_wr    (vol_wr),
        .i_busy      (wr_busy),
        .i_done      (wr_done),
        .o_start     (wr_start),
        .o_payload   (wr_payload),
        .o_init_done (init_done),
        .o_vol_done  (vol_done)
    );

    i2c_reg_writer #(
        .DEV_ADDR    (DEV_ADDR),
        .HALF_PERIOD (HALF_PERIOD)
    ) u_writer (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_start   (wr_start),
        .i_payload (wr_payload),
        .o_busy    (wr_busy),
        .o_done    (wr_done),
        .o_scl     (o_scl),
        .o_sda     (o_sda),
        .o_oen     (o_oen)
    );

endmodule

// File: testbench/i2c_frame_monitor.sv
module i2c_frame_monitor (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_scl,
    input  logic        i_sda,
    input  logic        i_oen,
    output logic        o_valid,
    output logic [23:0] o_frame,
    output logic        o_bad
);
    timeunit 1ns;
    timeprecision 100ps;

    logic        scl_d     = 1'b1;
    logic        sda_d     = 1'b1;
    logic        in_frame  = 1'b0;
    logic        slot_ok   = 1'b1;
    logic [4:0]  slot_cnt  = '0;
    logic [23:0] data_bits = '0;
    logic        start_seen;
    logic        stop_seen;
    logic        scl_rise;
    logic        ack_slot;

    assign start_seen = i_scl && scl_d && sda_d && !i_sda;   // SDA falls, SCL high
    assign stop_seen  = i_scl && scl_d && !sda_d && i_sda;   // SDA rises, SCL high
    assign scl_rise   = i_scl && !scl_d;
    assign ack_slot   = (slot_cnt == 5'd8) || (slot_cnt == 5'd17) || (slot_cnt == 5'd26);

    always @(posedge i_clk) begin
        scl_d   <= i_scl;
        sda_d   <= i_sda;
        o_valid <= 1'b0;
        o_bad   <= 1'b0;
        if (i_rst_n) begin
            in_frame <= 1'b0;
        end else if (start_seen) begin
            in_frame  <= 1'b1;
            slot_ok   <= 1'b1;
            slot_cnt  <= '0;
            data_bits <= '0;
        end else if (stop_seen && in_frame) begin
            in_frame <= 1'b0;
            o_frame  <= data_bits;
            // 27 slots plus the clock pulse of the stop condition
            if (slot_ok && slot_cnt == 5'd28) begin
                o_valid <= 1'b1;
            end else begin
                o_bad <= 1'b1;
            end
        end else if (scl_rise && in_frame) begin
            slot_cnt <= slot_cnt + 5'd1;
            if (!i_oen != ack_slot) slot_ok <= 1'b0;   // Oen low marks the ack slot
            if (i_oen && slot_cnt < 5'd27) begin
                data_bits <= {data_bits[22:0], i_sda};
            end
        end
    end

endmodule

// File: testbench/codec_cfg_assert.sv
module codec_cfg_assert (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_scl,
    input logic i_sda,
    input logic i_oen,
    input logic i_start,
    input logic i_busy
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Oen only moves when SCL falls at a slot boundary
    oen_at_slot_edge: assert property (@(posedge i_clk) disable iff (i_rst_n)
        $changed(i_oen) |-> $fell(i_scl))
        else begin
            $error("oen changed without a falling SCL");
            fail_count++;
        end

    // Ack slots release SDA and only occur inside a frame
    oen_low_in_frame: assert property (@(posedge i_clk) disable iff (i_rst_n)
        !i_oen |-> (i_sda && i_busy))
        else begin
            $error("oen low outside an ack slot of a frame");
            fail_count++;
        end

    // SDA may only fall for a start or rise for a stop while SCL stays high
    sda_stable_scl_high: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (i_scl && $past(i_scl) && $changed(i_sda)) |->
        (($rose(i_busy) && !i_sda) || ($fell(i_busy) && i_sda)))
        else begin
            $error("SDA changed while SCL was high");
            fail_count++;
        end

    // Each grant finds the writer idle and starts a frame on the next cycle
    grant_when_idle: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_start |=> (i_busy && !i_start && !$past(i_busy)))
        else begin
            $error("grant pulse overlapped busy or was not taken by the writer");
            fail_count++;
        end

endmodule

bind codec_cfg_top codec_cfg_assert u_assert (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_scl   (o_scl),
    .i_sda   (o_sda),
    .i_oen   (o_oen),
    .i_start (wr_start),
    .i_busy  (wr_busy)
);

// File: testbench/tb_codec_cfg.sv
module tb_codec_cfg import codec_cfg_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam dev_addr_t DEV_ADDR     = 7'h1A;
    localparam int        HALF_PERIOD  = 4;
    localparam int        FRAME_CYCLES = 2 * HALF_PERIOD * 30;   // Frame plus some margin
    localparam int        N_ROWS       = 8;

    typedef enum logic [2:0] {
        ACT_RESET,
        ACT_START,
        ACT_UP,
        ACT_DOWN,
        ACT_START_UP
    } action_t;

    typedef struct packed {
        action_t          action;
        logic [7:0]       count;
        logic [3:0]       n_frames;
        logic [7:0][23:0] frames;     // Address, register and data bytes
        volume_t          exp_vol;
        logic             exp_fin;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        vol_up;
    logic        vol_down;
    logic        finished;
    volume_t     volume;
    logic        scl;
    logic        sda;
    logic        oen;
    logic        mon_valid;
    logic [23:0] mon_frame;
    logic        mon_bad;
    logic [23:0] seen_frames[$];
    row_t        rows [N_ROWS];
    int          checks;
    int          errors;
    int          row_errors;
    int          monitor_errors;

    codec_cfg_top #(
        .DEV_ADDR    (DEV_ADDR),
        .HALF_PERIOD (HALF_PERIOD),
        .VOL_RESET   (7'h79),
        .VOL_MIN     (7'h30)
    ) uut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_start    (start),
        .i_vol_up   (vol_up),
        .i_vol_down (vol_down),
        .o_finished (finished),
        .o_volume   (volume),
        .o_scl      (scl),
        .o_sda      (sda),
        .o_oen      (oen)
    );

    i2c_frame_monitor u_monitor (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_scl   (scl),
        .i_sda   (sda),
        .i_oen   (oen),
        .o_valid (mon_valid),
        .o_frame (mon_frame),
        .o_bad   (mon_bad)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (mon_valid) seen_frames.push_back(mon_frame);
        if (mon_bad) begin
            $display("Monitor saw a malformed frame at %0t", $time);
            monitor_errors++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            row_errors++;
        end
    endtask

    task automatic set_row(input int i, input action_t act, input int count,
                           input volume_t vol, input logic fin);
        rows[i]         = '0;
        rows[i].action  = act;
        rows[i].count   = 8'(count);
        rows[i].exp_vol = vol;
        rows[i].exp_fin = fin;
    endtask

    task automatic add_frame(input int i, input reg_addr_t addr, input reg_data_t data);
        rows[i].frames[rows[i].n_frames] = {DEV_ADDR, 1'b0, addr, data}; // R/W low
        rows[i].n_frames = rows[i].n_frames + 4'd1;
    endtask

    // Both channels linked with zero-cross off
    task automatic add_volume_frame(input int i, input volume_t vol);
        add_frame(i, 7'h02, {1'b1, 1'b0, vol});
    endtask

    task automatic add_init_frames(input int i);
        add_frame(i, 7'h0F, 9'h000);
        add_frame(i, 7'h04, 9'h015);
        add_frame(i, 7'h05, 9'h000);
        add_frame(i, 7'h06, 9'h000);
        add_frame(i, 7'h07, 9'h042);
        add_frame(i, 7'h08, 9'h019);
        add_frame(i, 7'h09, 9'h001);
    endtask

    task automatic build_table();
        set_row(0, ACT_RESET, 3, 7'h79, 1'b0);
        set_row(1, ACT_START, 1, 7'h79, 1'b1);
        add_init_frames(1);
        set_row(2, ACT_UP, 8, 7'h7F, 1'b1);   // First pulse written and the rest folded
        add_volume_frame(2, 7'h7A);
        add_volume_frame(2, 7'h7F);
        set_row(3, ACT_UP, 1, 7'h7F, 1'b1);
        set_row(4, ACT_DOWN, 82, 7'h30, 1'b1);
        add_volume_frame(4, 7'h7E);
        add_volume_frame(4, 7'h30);
        set_row(5, ACT_DOWN, 2, 7'h30, 1'b1);
        set_row(6, ACT_START_UP, 1, 7'h31, 1'b1);
        add_init_frames(6);
        add_volume_frame(6, 7'h31);          // Only after the seventh init write
        set_row(7, ACT_RESET, 3, 7'h79, 1'b0);
    endtask

    function automatic string action_label(input action_t act);
        case (act)
            ACT_RESET: return "reset";
            ACT_START: return "start";
            ACT_UP:    return "volume up";
            ACT_DOWN:  return "volume down";
            default:   return "start with volume up";
        endcase
    endfunction

    task automatic pulse_volume(input logic up, input int count);
        for (int k = 0; k < count; k++) begin
            @(posedge clk);
            vol_up   <= up;
            vol_down <= !up;
            @(posedge clk);
            vol_up   <= 1'b0;
            vol_down <= 1'b0;
        end
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic apply_action(input row_t row);
        case (row.action)
            ACT_RESET: begin
                @(posedge clk);
                rst_n <= 1'b1;
                repeat (row.count) @(posedge clk);
                rst_n <= 1'b0;
            end
            ACT_START: pulse_start();
            ACT_UP:    pulse_volume(1'b1, row.count);
            ACT_DOWN:  pulse_volume(1'b0, row.count);
            default: begin
                pulse_start();
                repeat (20) @(posedge clk);       // Lands inside the first init frame
                pulse_volume(1'b1, row.count);
            end
        endcase
    endtask

    task automatic wait_frames(input int count);
        int cycles;
        cycles = 0;
        while (seen_frames.size() < count && cycles < 2 * count * FRAME_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (seen_frames.size() < count) begin
            $display("Timeout at %0t: only %0d of %0d frames seen",
                     $time, seen_frames.size(), count);
            row_errors++;
        end
    endtask

    task automatic wait_finished(input logic level);
        int cycles;
        cycles = 0;
        while (finished !== level && cycles < FRAME_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (finished !== level) begin
            $display("Timeout at %0t: o_finished never reached %b", $time, level);
            row_errors++;
        end
    endtask

    task automatic run_row(input int r);
        row_t row;
        row        = rows[r];
        row_errors = 0;
        seen_frames.delete();
        apply_action(row);
        if (row.action == ACT_START || row.action == ACT_START_UP) begin
            wait_finished(1'b0);   // A new run clears finished first
        end
        wait_frames(row.n_frames);
        wait_finished(row.exp_fin);
        repeat (FRAME_CYCLES + 20) @(negedge clk);   // Room for a stray frame to show up
        check_value("frame count", seen_frames.size(), row.n_frames);
        for (int k = 0; k < row.n_frames && seen_frames.size() > 0; k++) begin
            check_value($sformatf("frame %0d", k), seen_frames.pop_front(), row.frames[k]);
        end
        check_value("o_volume", volume, row.exp_vol);
        check_value("o_finished", finished, row.exp_fin);
        check_value("o_scl", scl, 1'b1);   // Bus idle between rows
        check_value("o_sda", sda, 1'b1);
        check_value("o_oen", oen, 1'b1);
        errors += row_errors;
        $display("Row %0d, %s x%0d: %0d errors", r, action_label(row.action),
                 row.count, row_errors);
    endtask

    initial begin
        int total;
        clk            = 1'b0;
        rst_n          = 1'b1;
        start          = 1'b0;
        vol_up         = 1'b0;
        vol_down       = 1'b0;
        checks         = 0;
        errors         = 0;
        monitor_errors = 0;
        build_table();
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        total = errors + monitor_errors + uut.u_assert.fail_count;
        $display("Rows run: %0d, checks: %0d, errors: %0d", N_ROWS, checks, total);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: codec_cfg_top.f
source/codec_cfg_pkg.sv
source/codec_init_seq.sv
source/codec_volume_ctrl.sv
source/i2c_bus_arbiter.sv
source/i2c_reg_writer.sv
source/codec_cfg_top.sv
testbench/i2c_frame_monitor.sv
testbench/codec_cfg_assert.sv
testbench/tb_codec_cfg.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_codec_cfg
FILELIST  := codec_cfg_top.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
RUN_ARGS  := +verilator+error+limit+100
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	$(SIM) $(RUN_ARGS) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "Run failed"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "Run ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
